/* rtl/cache_pkg.sv */
// Cache address fields shared by the MSHR and by the cache around it
// A line address is the tag placed above the cache set index
package cache_pkg;

    localparam int unsigned set_width  = 6;
    localparam int unsigned tag_width  = 20;
    localparam int unsigned way_width  = 2;
    localparam int unsigned word_width = 3;

    // Set index inside the data cache
    typedef logic [set_width-1:0] set_t;

    // Tag kept per cache line
    typedef logic [tag_width-1:0] tag_t;

    // Victim way chosen in the cache on a miss
    typedef logic [way_width-1:0] cache_way_t;

    // Word offset of the missing access inside the line
    typedef logic [word_width-1:0] word_t;

    // Line address, tag in the upper bits
    typedef struct packed {
        tag_t tag;
        set_t set;
    } nline_t;

endpackage

/* rtl/mshr_pkg.sv */
// Records held by the MSHR: stored entry, allocation request and
// acknowledge response, all as packed structs
package mshr_pkg;

    import cache_pkg::*;

    // Identifier of the request inside its requester
    typedef logic [3:0] req_id_t;

    // Identifier of the requester
    typedef logic [2:0] src_id_t;

    // One stored miss, kept in the entry RAM
    // The cache set is not stored here, it lives in flops next to the valid bits
    typedef struct packed {
        tag_t       tag;
        req_id_t    req_id;
        src_id_t    src_id;
        word_t      word;
        cache_way_t victim_way;
        logic       need_rsp;
        logic       is_prefetch;
    } mshr_entry_t;

    // New miss presented with alloc_i
    typedef struct packed {
        nline_t     nline;
        req_id_t    req_id;
        src_id_t    src_id;
        word_t      word;
        cache_way_t victim_way;
        logic       need_rsp;
        logic       is_prefetch;
    } mshr_alloc_t;

    // Contents of a freed slot, returned the cycle after ack_i
    typedef struct packed {
        mshr_entry_t entry;
        set_t        set;
        logic        make_inval;
        logic        make_shared;
    } mshr_ack_t;

endpackage

/* rtl/mshr_entry_ram.sv */
// Single-port entry storage of the MSHR, one row per MSHR set holding all ways
// Writes go to the ways selected by way_we_i, reads return the whole row next cycle
module mshr_entry_ram
    import mshr_pkg::*;
#(
    parameter int unsigned n_sets = 4,
    parameter int unsigned n_ways = 4
) (
    input  logic                         clk_i,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(n_sets)-1:0]    addr_i,
    input  logic [n_ways-1:0]            way_we_i,
    input  mshr_entry_t                  wentry_i,
    output mshr_entry_t [n_ways-1:0]     rentry_o
);

    localparam int unsigned set_w = $clog2(n_sets);

    typedef logic [set_w-1:0] mshr_set_t;

    mshr_entry_t [n_ways-1:0] mem_q [n_sets];
    mshr_set_t                row;

    assign row = addr_i;

    // Read returns the row as it was before a write in the same cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int w = 0; w < n_ways; w++) begin
                    if (way_we_i[w]) begin
                        mem_q[row][w] <= wentry_i;
                    end
                end
            end
            rentry_o <= mem_q[row];
        end
    end

endmodule

/* rtl/mshr_slot_state.sv */
// Per-slot state of the MSHR: valid bits, stored cache sets and snoop flags
// Also picks the free way for allocation, drives the entry RAM port and builds the ack response
module mshr_slot_state
    import cache_pkg::*;
    import mshr_pkg::*;
#(
    parameter int unsigned n_sets = 4,
    parameter int unsigned n_ways = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    // Allocation
    input  logic                          alloc_i,
    input  mshr_alloc_t                   alloc_req_i,
    output logic [$clog2(n_ways)-1:0]     alloc_way_o,

    // Acknowledge
    input  logic                          ack_i,
    input  logic [$clog2(n_sets)-1:0]     ack_set_i,
    input  logic [$clog2(n_ways)-1:0]     ack_way_i,

    // Check and snoop
    input  logic                          check_i,
    input  set_t                          check_set_i,
    input  logic                          make_shared_i,
    input  logic                          make_inval_i,
    input  logic                          hit_i,
    input  logic [$clog2(n_ways)-1:0]     hit_way_i,
    input  set_t                          check_set_q_i,

    // Entry RAM port
    output logic                          ram_en_o,
    output logic                          ram_we_o,
    output logic [$clog2(n_sets)-1:0]     ram_addr_o,
    output logic [n_ways-1:0]             ram_way_we_o,
    output mshr_entry_t                   ram_wentry_o,
    input  mshr_entry_t [n_ways-1:0]      rentry_i,

    // Status
    output logic [n_sets*n_ways-1:0]      valid_o,
    output set_t [n_sets*n_ways-1:0]      slot_set_o,
    output mshr_ack_t                     ack_rsp_o,
    output logic                          empty_o,
    output logic                          full_o
);

    localparam int unsigned set_w   = $clog2(n_sets);
    localparam int unsigned way_w   = $clog2(n_ways);
    localparam int unsigned n_slots = n_sets * n_ways;

    typedef logic [set_w-1:0]       mshr_set_t;
    typedef logic [way_w-1:0]       mshr_way_t;
    typedef logic [set_w+way_w-1:0] slot_idx_t;

    // Slot index is {mshr set, way}, so the ways of one set are adjacent
    logic [n_slots-1:0] valid_q;
    logic [n_slots-1:0] valid_d;
    logic [n_slots-1:0] shared_q;
    logic [n_slots-1:0] shared_d;
    logic [n_slots-1:0] inval_q;
    logic [n_slots-1:0] inval_d;
    set_t [n_slots-1:0] slot_set_q;

    mshr_set_t   alloc_set;
    mshr_way_t   free_way;
    slot_idx_t   alloc_slot;
    slot_idx_t   ack_slot;
    slot_idx_t   snoop_slot;
    logic        snoop_shared;
    logic        snoop_inval;
    logic        snoop_on_ack;

    logic        ack_rd_q;
    mshr_way_t   ack_way_q;
    set_t        ack_set_q;
    logic        ack_shared_q;
    logic        ack_inval_q;
    mshr_entry_t ack_entry_q;

    assign alloc_set  = alloc_req_i.nline.set[set_w-1:0];
    assign alloc_slot = {alloc_set, free_way};
    assign ack_slot   = {ack_set_i, ack_way_i};

    // Snoop marks the slot found by the previous cycle's check
    assign snoop_slot   = {check_set_q_i[set_w-1:0], hit_way_i};
    assign snoop_shared = hit_i & make_shared_i;
    assign snoop_inval  = hit_i & make_inval_i;
    assign snoop_on_ack = (snoop_slot == ack_slot);

    // Lowest free way of the allocation set, way 0 when the set is full
    always_comb begin
        free_way = '0;
        for (int w = n_ways - 1; w >= 0; w--) begin
            if (!valid_q[{alloc_set, mshr_way_t'(w)}]) begin
                free_way = mshr_way_t'(w);
            end
        end
    end

    assign alloc_way_o = free_way;

    always_comb begin
        valid_d  = valid_q;
        shared_d = shared_q;
        inval_d  = inval_q;
        if (snoop_shared) begin
            shared_d[snoop_slot] = 1'b1;
        end
        if (snoop_inval) begin
            inval_d[snoop_slot] = 1'b1;
        end
        if (ack_i) begin
            valid_d[ack_slot]  = 1'b0;
            shared_d[ack_slot] = 1'b0;
            inval_d[ack_slot]  = 1'b0;
        end else if (alloc_i) begin
            valid_d[alloc_slot]  = 1'b1;
            shared_d[alloc_slot] = 1'b0;
            inval_d[alloc_slot]  = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            shared_q <= '0;
            inval_q  <= '0;
            ack_rd_q <= 1'b0;
        end else begin
            valid_q  <= valid_d;
            shared_q <= shared_d;
            inval_q  <= inval_d;
            ack_rd_q <= ack_i;
        end
    end

    // Acknowledge capture, flags include a snoop landing in the same cycle
    always_ff @(posedge clk_i) begin
        if (alloc_i && !ack_i) begin
            slot_set_q[alloc_slot] <= alloc_req_i.nline.set;
        end
        if (ack_i) begin
            ack_way_q    <= ack_way_i;
            ack_set_q    <= slot_set_q[ack_slot];
            ack_shared_q <= shared_q[ack_slot] | (snoop_shared & snoop_on_ack);
            ack_inval_q  <= inval_q[ack_slot] | (snoop_inval & snoop_on_ack);
        end
        if (ack_rd_q) begin
            ack_entry_q <= rentry_i[ack_way_q];
        end
    end

    // RAM read data is live for one cycle only, held copy afterwards
    always_comb begin
        ack_rsp_o.entry       = ack_rd_q ? rentry_i[ack_way_q] : ack_entry_q;
        ack_rsp_o.set         = ack_set_q;
        ack_rsp_o.make_inval  = ack_inval_q;
        ack_rsp_o.make_shared = ack_shared_q;
    end

    // One RAM port, acknowledge first, then allocate, then check
    assign ram_en_o   = ack_i | alloc_i | check_i;
    assign ram_we_o   = alloc_i & ~ack_i;
    assign ram_addr_o = ack_i   ? ack_set_i :
                        alloc_i ? alloc_set : check_set_i[set_w-1:0];

    always_comb begin
        for (int w = 0; w < n_ways; w++) begin
            ram_way_we_o[w] = (free_way == mshr_way_t'(w));
        end
    end

    always_comb begin
        ram_wentry_o.tag         = alloc_req_i.nline.tag;
        ram_wentry_o.req_id      = alloc_req_i.req_id;
        ram_wentry_o.src_id      = alloc_req_i.src_id;
        ram_wentry_o.word        = alloc_req_i.word;
        ram_wentry_o.victim_way  = alloc_req_i.victim_way;
        ram_wentry_o.need_rsp    = alloc_req_i.need_rsp;
        ram_wentry_o.is_prefetch = alloc_req_i.is_prefetch;
    end

    assign valid_o    = valid_q;
    assign slot_set_o = slot_set_q;
    assign empty_o    = ~|valid_q;
    assign full_o     = &valid_q;

endmodule

/* rtl/mshr_hit_check.sv */
// Second stage of an MSHR check: holds the checked cache set and compares
// it against the valid slots and the RAM tags read in the first stage
module mshr_hit_check
    import cache_pkg::*;
    import mshr_pkg::*;
#(
    parameter int unsigned n_sets = 4,
    parameter int unsigned n_ways = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          check_i,
    input  logic                          alloc_i,
    input  set_t                          check_set_i,
    // Tag arrives one cycle after check_i
    input  tag_t                          check_tag_i,
    input  logic [n_sets*n_ways-1:0]      valid_i,
    input  set_t [n_sets*n_ways-1:0]      slot_set_i,
    input  mshr_entry_t [n_ways-1:0]      rentry_i,
    output logic                          hit_o,
    output logic [$clog2(n_ways)-1:0]     hit_way_o,
    output logic                          alloc_full_o,
    output set_t                          check_set_q_o
);

    localparam int unsigned set_w = $clog2(n_sets);
    localparam int unsigned way_w = $clog2(n_ways);

    typedef logic [set_w-1:0] mshr_set_t;
    typedef logic [way_w-1:0] mshr_way_t;

    set_t              check_set_q;
    mshr_set_t         held_set;
    logic [n_ways-1:0] hit_vec;
    logic [n_ways-1:0] free_vec;

    // An allocation in the same cycle takes the RAM port, the check is dropped
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            check_set_q <= '0;
        end else if (check_i && !alloc_i) begin
            check_set_q <= check_set_i;
        end
    end

    assign held_set = check_set_q[set_w-1:0];

    // Several cache sets share one MSHR set, so the full cache set is compared too
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < n_ways; w++) begin
            free_vec[w] = !valid_i[{held_set, mshr_way_t'(w)}];
            hit_vec[w]  = valid_i[{held_set, mshr_way_t'(w)}] &&
                          (slot_set_i[{held_set, mshr_way_t'(w)}] == check_set_q) &&
                          (rentry_i[w].tag == check_tag_i);
            if (hit_vec[w]) begin
                hit_way_o = mshr_way_t'(w);
            end
        end
    end

    assign hit_o         = |hit_vec;
    assign alloc_full_o  = ~|free_vec;
    assign check_set_q_o = check_set_q;

endmodule

/* rtl/mshr.sv */
// Miss status holding register of a non-blocking data cache, n_sets x n_ways slots
// Check, allocate and acknowledge share one entry RAM port; both sizes are powers of two, >= 2
module mshr
    import cache_pkg::*;
    import mshr_pkg::*;
#(
    parameter int unsigned n_sets = 4,
    parameter int unsigned n_ways = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    // Check, result one cycle later, check_tag_i given in that later cycle
    input  logic                          check_i,
    input  set_t                          check_set_i,
    input  tag_t                          check_tag_i,
    output logic                          hit_o,

    // Allocate, takes priority over a check in the same cycle
    input  logic                          alloc_i,
    input  mshr_alloc_t                   alloc_req_i,
    output logic                          alloc_full_o,
    output logic [$clog2(n_ways)-1:0]     alloc_way_o,

    // Snoop levels, only in the cycle where hit_o is high
    input  logic                          make_shared_i,
    input  logic                          make_inval_i,

    // Acknowledge, never in the same cycle as check or allocate
    input  logic                          ack_i,
    input  logic [$clog2(n_sets)-1:0]     ack_set_i,
    input  logic [$clog2(n_ways)-1:0]     ack_way_i,
    output mshr_ack_t                     ack_rsp_o,

    output logic                          empty_o,
    output logic                          full_o
);

    localparam int unsigned set_w   = $clog2(n_sets);
    localparam int unsigned way_w   = $clog2(n_ways);
    localparam int unsigned n_slots = n_sets * n_ways;

    logic                     ram_en;
    logic                     ram_we;
    logic [set_w-1:0]         ram_addr;
    logic [n_ways-1:0]        ram_way_we;
    mshr_entry_t              ram_wentry;
    mshr_entry_t [n_ways-1:0] ram_rentry;

    logic [n_slots-1:0]       slot_valid;
    set_t [n_slots-1:0]       slot_set;
    logic [way_w-1:0]         hit_way;
    set_t                     check_set_q;

    mshr_entry_ram #(
        .n_sets (n_sets),
        .n_ways (n_ways)
    ) u_ram (
        .clk_i    (clk_i),
        .en_i     (ram_en),
        .we_i     (ram_we),
        .addr_i   (ram_addr),
        .way_we_i (ram_way_we),
        .wentry_i (ram_wentry),
        .rentry_o (ram_rentry)
    );

    mshr_slot_state #(
        .n_sets (n_sets),
        .n_ways (n_ways)
    ) u_slot_state (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (alloc_i),
        .alloc_req_i   (alloc_req_i),
        .alloc_way_o   (alloc_way_o),
        .ack_i         (ack_i),
        .ack_set_i     (ack_set_i),
        .ack_way_i     (ack_way_i),
        .check_i       (check_i),
        .check_set_i   (check_set_i),
        .make_shared_i (make_shared_i),
        .make_inval_i  (make_inval_i),
        .hit_i         (hit_o),
        .hit_way_i     (hit_way),
        .check_set_q_i (check_set_q),
        .ram_en_o      (ram_en),
        .ram_we_o      (ram_we),
        .ram_addr_o    (ram_addr),
        .ram_way_we_o  (ram_way_we),
        .ram_wentry_o  (ram_wentry),
        .rentry_i      (ram_rentry),
        .valid_o       (slot_valid),
        .slot_set_o    (slot_set),
        .ack_rsp_o     (ack_rsp_o),
        .empty_o       (empty_o),
        .full_o        (full_o)
    );

    mshr_hit_check #(
        .n_sets (n_sets),
        .n_ways (n_ways)
    ) u_hit_check (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check_i),
        .alloc_i       (alloc_i),
        .check_set_i   (check_set_i),
        .check_tag_i   (check_tag_i),
        .valid_i       (slot_valid),
        .slot_set_i    (slot_set),
        .rentry_i      (ram_rentry),
        .hit_o         (hit_o),
        .hit_way_o     (hit_way),
        .alloc_full_o  (alloc_full_o),
        .check_set_q_o (check_set_q)
    );

endmodule

/* bench/mshr_tb.sv */
// Testbench of the MSHR with random check, allocate, acknowledge and snoop traffic
// Every response is compared against a slot model kept here
// Built and run through the Makefile
module mshr_tb
    import cache_pkg::*;
    import mshr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned n_sets     = 4;
    localparam int unsigned n_ways     = 4;
    localparam int unsigned set_w      = $clog2(n_sets);
    localparam int unsigned way_w      = $clog2(n_ways);
    localparam int unsigned n_slots    = n_sets * n_ways;
    localparam int unsigned n_rand_ops = 300;
    // Room for about 600 operations of up to 3 cycles each plus margin
    localparam int unsigned max_cycles = 4000;

    typedef logic [set_w-1:0] mset_t;
    typedef logic [way_w-1:0] way_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        check_i;
    set_t        check_set_i;
    tag_t        check_tag_i;
    logic        hit_o;
    logic        alloc_i;
    mshr_alloc_t alloc_req_i;
    logic        alloc_full_o;
    way_t        alloc_way_o;
    logic        make_shared_i;
    logic        make_inval_i;
    logic        ack_i;
    mset_t       ack_set_i;
    way_t        ack_way_i;
    mshr_ack_t   ack_rsp_o;
    logic        empty_o;
    logic        full_o;

    // Slot model indexed by mshr set * n_ways + way
    logic        m_valid  [n_slots];
    set_t        m_set    [n_slots];
    mshr_entry_t m_entry  [n_slots];
    logic        m_shared [n_slots];
    logic        m_inval  [n_slots];

    // Last acknowledge response, held by the DUT until the next acknowledge
    mshr_ack_t   last_ack;
    logic        ack_seen = 1'b0;

    int unsigned cycle_cnt = 0;
    int unsigned tag_cnt   = 0;

    mshr #(
        .n_sets (n_sets),
        .n_ways (n_ways)
    ) u_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check_i),
        .check_set_i   (check_set_i),
        .check_tag_i   (check_tag_i),
        .hit_o         (hit_o),
        .alloc_i       (alloc_i),
        .alloc_req_i   (alloc_req_i),
        .alloc_full_o  (alloc_full_o),
        .alloc_way_o   (alloc_way_o),
        .make_shared_i (make_shared_i),
        .make_inval_i  (make_inval_i),
        .ack_i         (ack_i),
        .ack_set_i     (ack_set_i),
        .ack_way_i     (ack_way_i),
        .ack_rsp_o     (ack_rsp_o),
        .empty_o       (empty_o),
        .full_o        (full_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("ERRORS FOUND");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles", max_cycles);
        end
    end

    task automatic compare_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on a level");
        end
    endtask

    task automatic compare_way(input string name, input way_t exp, input way_t act);
        if (act !== exp) begin
            $display("Fail %s expected %0d actual %0d", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on a way");
        end
    endtask

    task automatic compare_ack(input string name, input mshr_ack_t exp, input mshr_ack_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on an acknowledge response");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    function automatic int free_way_of(input set_t cset);
        int base;
        base = int'(cset[set_w-1:0]) * n_ways;
        for (int w = 0; w < n_ways; w++) begin
            if (!m_valid[base + w]) return w;
        end
        return -1;
    endfunction

    // A hit needs equal cache set and tag, not only the same MSHR set
    function automatic int hit_slot_of(input nline_t line);
        int base;
        base = int'(line.set[set_w-1:0]) * n_ways;
        for (int w = 0; w < n_ways; w++) begin
            if (m_valid[base + w] && m_set[base + w] == line.set &&
                m_entry[base + w].tag == line.tag) return base + w;
        end
        return -1;
    endfunction

    function automatic int random_valid_slot();
        int start;
        start = int'($urandom_range(0, n_slots - 1));
        for (int i = 0; i < n_slots; i++) begin
            if (m_valid[(start + i) % n_slots]) return (start + i) % n_slots;
        end
        return -1;
    endfunction

    // Few tags and cache sets make lines collide often in the low set bits
    function automatic nline_t random_line();
        nline_t line;
        line.set = set_t'($urandom_range(0, 7));
        line.tag = tag_t'(32'h100 + $urandom_range(0, 2));
        return line;
    endfunction

    // Unique tag with any cache set that maps to the given MSHR set
    function automatic nline_t fresh_line(input int mset);
        nline_t line;
        line.set = set_t'($urandom_range(0, 15) * n_sets + mset);
        line.tag = tag_t'(32'h80000 + tag_cnt);
        tag_cnt++;
        return line;
    endfunction

    function automatic mshr_alloc_t random_req(input nline_t line);
        mshr_alloc_t req;
        req.nline       = line;
        req.req_id      = req_id_t'($urandom());
        req.src_id      = src_id_t'($urandom());
        req.word        = word_t'($urandom());
        req.victim_way  = cache_way_t'($urandom());
        req.need_rsp    = 1'($urandom_range(0, 1));
        req.is_prefetch = 1'($urandom_range(0, 1));
        return req;
    endfunction

    function automatic mshr_entry_t entry_of(input mshr_alloc_t req);
        mshr_entry_t e;
        e.tag         = req.nline.tag;
        e.req_id      = req.req_id;
        e.src_id      = req.src_id;
        e.word        = req.word;
        e.victim_way  = req.victim_way;
        e.need_rsp    = req.need_rsp;
        e.is_prefetch = req.is_prefetch;
        return e;
    endfunction

    task automatic compare_status(input string name);
        int n;
        n = 0;
        for (int s = 0; s < n_slots; s++) begin
            if (m_valid[s]) n++;
        end
        compare_level({name, " empty"}, n == 0, empty_o);
        compare_level({name, " full"}, n == n_slots, full_o);
    endtask

    // Check in one cycle and tag, snoop levels and result in the next
    task automatic run_check(input nline_t line, input string name,
                             input logic shared, input logic inval);
        int slot;
        int fw;
        check_i     = 1'b1;
        check_set_i = line.set;
        next_cycle();
        check_i     = 1'b0;
        check_tag_i = line.tag;
        slot = hit_slot_of(line);
        fw   = free_way_of(line.set);
        if (slot >= 0) begin
            make_shared_i = shared;
            make_inval_i  = inval;
        end
        @(negedge clk_i);
        compare_level({name, " hit"}, slot >= 0, hit_o);
        compare_level({name, " set full"}, fw < 0, alloc_full_o);
        compare_status(name);
        if (ack_seen) begin
            compare_ack({name, " held ack"}, last_ack, ack_rsp_o);
        end
        next_cycle();
        make_shared_i = 1'b0;
        make_inval_i  = 1'b0;
        if (slot >= 0) begin
            m_shared[slot] = m_shared[slot] | shared;
            m_inval[slot]  = m_inval[slot] | inval;
        end
    endtask

    task automatic run_alloc(input mshr_alloc_t req, input string name);
        int fw;
        int slot;
        fw          = free_way_of(req.nline.set);
        alloc_i     = 1'b1;
        alloc_req_i = req;
        @(negedge clk_i);
        compare_way({name, " way"}, way_t'(fw), alloc_way_o);
        next_cycle();
        alloc_i = 1'b0;
        slot = int'(req.nline.set[set_w-1:0]) * n_ways + fw;
        m_valid[slot]  = 1'b1;
        m_set[slot]    = req.nline.set;
        m_entry[slot]  = entry_of(req);
        m_shared[slot] = 1'b0;
        m_inval[slot]  = 1'b0;
    endtask

    task automatic run_ack(input int slot, input string name);
        mshr_ack_t exp;
        exp.entry       = m_entry[slot];
        exp.set         = m_set[slot];
        exp.make_inval  = m_inval[slot];
        exp.make_shared = m_shared[slot];
        ack_i     = 1'b1;
        ack_set_i = mset_t'(slot / n_ways);
        ack_way_i = way_t'(slot % n_ways);
        next_cycle();
        ack_i = 1'b0;
        m_valid[slot]  = 1'b0;
        m_shared[slot] = 1'b0;
        m_inval[slot]  = 1'b0;
        @(negedge clk_i);
        compare_ack(name, exp, ack_rsp_o);
        compare_status(name);
        last_ack = exp;
        ack_seen = 1'b1;
        next_cycle();
    endtask

    initial begin
        nline_t line;
        int     slot;
        logic   shared;
        logic   inval;
        void'($urandom(20));
        rst_ni        = 1'b0;
        check_i       = 1'b0;
        check_set_i   = '0;
        check_tag_i   = '0;
        alloc_i       = 1'b0;
        alloc_req_i   = '0;
        make_shared_i = 1'b0;
        make_inval_i  = 1'b0;
        ack_i         = 1'b0;
        ack_set_i     = '0;
        ack_way_i     = '0;
        for (int s = 0; s < n_slots; s++) begin
            m_valid[s]  = 1'b0;
            m_set[s]    = '0;
            m_entry[s]  = '0;
            m_shared[s] = 1'b0;
            m_inval[s]  = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        @(negedge clk_i);
        compare_status("after reset");
        next_cycle();
        repeat (4) run_check(random_line(), "check after reset", 1'b0, 1'b0);

        // Random traffic that allocates on a miss and sometimes frees a slot
        for (int i = 0; i < n_rand_ops; i++) begin
            slot = random_valid_slot();
            if ($urandom_range(0, 3) == 0 && slot >= 0) begin
                line = {m_entry[slot].tag, m_set[slot]};
                run_ack(slot, "random ack");
                run_check(line, "check after ack", 1'b0, 1'b0);
            end else begin
                line = random_line();
                run_check(line, "random check", 1'($urandom_range(0, 1)),
                          1'($urandom_range(0, 1)));
                if (hit_slot_of(line) < 0 && free_way_of(line.set) >= 0) begin
                    run_alloc(random_req(line), "random alloc");
                end
            end
        end

        // Fill every MSHR set and check each once more when full
        for (int s = 0; s < n_sets; s++) begin
            line = fresh_line(s);
            while (free_way_of(line.set) >= 0) begin
                run_check(line, "fill check", 1'b0, 1'b0);
                run_alloc(random_req(line), "fill alloc");
                line = fresh_line(s);
            end
            run_check(line, "full set check", 1'b0, 1'b0);
        end

        // Drain in random order
        slot = random_valid_slot();
        while (slot >= 0) begin
            line = {m_entry[slot].tag, m_set[slot]};
            run_ack(slot, "drain ack");
            run_check(line, "drain check", 1'b0, 1'b0);
            slot = random_valid_slot();
        end

        // Snoop marks reach the ack and a reused slot starts with clear flags
        repeat (8) begin
            line = fresh_line(int'($urandom_range(0, n_sets - 1)));
            run_check(line, "snoop miss", 1'b0, 1'b0);
            run_alloc(random_req(line), "snoop alloc");
            shared = 1'($urandom_range(0, 1));
            inval  = ~shared | 1'($urandom_range(0, 1));
            run_check(line, "snoop hit", shared, inval);
            slot = hit_slot_of(line);
            run_ack(slot, "snoop ack");
            line = fresh_line(int'(line.set[set_w-1:0]));
            run_check(line, "realloc miss", 1'b0, 1'b0);
            run_alloc(random_req(line), "realloc");
            run_ack(hit_slot_of(line), "realloc ack");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* mshr.f */
rtl/cache_pkg.sv
rtl/mshr_pkg.sv
rtl/mshr_entry_ram.sv
rtl/mshr_slot_state.sv
rtl/mshr_hit_check.sv
rtl/mshr.sv
bench/mshr_tb.sv

/* Makefile */
SRCS := $(shell cat mshr.f)

obj_dir/Vmshr_tb: mshr.f $(SRCS)
	verilator --binary --top-module mshr_tb -f mshr.f -o Vmshr_tb

.PHONY: run clean

run: obj_dir/Vmshr_tb
	./obj_dir/Vmshr_tb

clean:
	rm -rf obj_dir
